// ==== include/arcade_io_defines.svh ====
// Arcade board I/O shared constants
// Keyboard scan codes, menu status bit positions and the audio DAC width

`ifndef ARCADE_IO_DEFINES_SVH
`define ARCADE_IO_DEFINES_SVH

// ------------------------------
// Keyboard scan codes
// ------------------------------
`define KEY_UP      8'h75
`define KEY_DOWN    8'h72
`define KEY_LEFT    8'h6B
`define KEY_RIGHT   8'h74
`define KEY_COIN    8'h76 // ESC
`define KEY_START1  8'h05 // F1
`define KEY_START2  8'h06 // F2
`define KEY_FIRE1   8'h29 // Space
`define KEY_FIRE2   8'h11 // Alt

// ------------------------------
// Menu status word bit positions
// ------------------------------
`define STATUS_RESET       0
`define STATUS_ROTATE      2
`define STATUS_SCAN_LO     3 // Scanline level, bits 4:3
`define STATUS_RESET_MENU  6

// Accumulator width of the audio DAC
`define DAC_BITS  15

`endif

// ==== verilog/arcade_io_pkg.sv ====
// Arcade board I/O types
// Vector types for the board signals and the packed structs that carry
// key levels, game controls and video between the blocks

`default_nettype none

package arcade_io_pkg;

	typedef logic [7:0]  key_code_t; // Keyboard scan code
	typedef logic [7:0]  joy_t;      // 0 right, 1 left, 2 down, 3 up, 4 fire, 5 barrier
	typedef logic [31:0] status_t;   // Menu status word
	typedef logic [1:0]  color2_t;   // Game colour channel
	typedef logic [5:0]  color6_t;   // VGA colour channel
	typedef logic [11:0] audio_t;    // Game audio sample

	// Held keyboard levels
	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic coin;
		logic start1;
		logic start2;
		logic fire1;
		logic fire2;
	} key_buttons_t;

	// Inputs to the game core
	typedef struct packed {
		logic coin;
		logic start1;
		logic start2;
		logic left;
		logic right;
		logic fire;
		logic barrier;
	} game_ctrl_t;

	// Raw game video, syncs and blanks active high
	typedef struct packed {
		color2_t r;
		color2_t g;
		color2_t b;
		logic    hs;
		logic    vs;
		logic    hb_bg;
		logic    hb_fg;
		logic    vb;
	} game_video_t;

	// Board VGA output
	typedef struct packed {
		color6_t r;
		color6_t g;
		color6_t b;
		logic    hs_n;
		logic    vs_n;
	} vga_out_t;

endpackage

`default_nettype wire

// ==== verilog/key_latch.sv ====
// Keyboard key latch
// Strobed key events (code and pressed level) become held button levels,
// one per known key; unknown codes leave every level as it is

`default_nettype none

`include "arcade_io_defines.svh"

module key_latch
	import arcade_io_pkg::*;
(
	input  logic         clk_sys,
	input  logic         rst_n,
	input  logic         key_strobe,  // One cycle per key event
	input  logic         key_pressed, // 1 make, 0 break
	input  key_code_t    key_code,
	output key_buttons_t buttons
);

	key_buttons_t held;

	// ------------------------------
	// Key event decode
	// ------------------------------
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			held <= '0;
		end else if (key_strobe) begin
			case (key_code)
				`KEY_UP: begin
					held.up <= key_pressed;
				end
				`KEY_DOWN: begin
					held.down <= key_pressed;
				end
				`KEY_LEFT: begin
					held.left <= key_pressed;
				end
				`KEY_RIGHT: begin
					held.right <= key_pressed;
				end
				`KEY_COIN: begin
					held.coin <= key_pressed;
				end
				`KEY_START1: begin
					held.start1 <= key_pressed;
				end
				`KEY_START2: begin
					held.start2 <= key_pressed;
				end
				`KEY_FIRE1: begin
					held.fire1 <= key_pressed;
				end
				`KEY_FIRE2: begin
					held.fire2 <= key_pressed;
				end
				default: begin
					held <= held; // Unknown code, keep all levels
				end
			endcase
		end
	end

	assign buttons = held;

endmodule

`default_nettype wire

// ==== verilog/control_mapper.sv ====
// Game control mapper
// Merges keyboard buttons with both joysticks into the game inputs,
// picks normal or rotated direction sources and forms the game reset

`default_nettype none

`include "arcade_io_defines.svh"

module control_mapper
	import arcade_io_pkg::*;
(
	input  logic         clk_sys,
	input  logic         rst_n,
	input  key_buttons_t key_buttons,
	input  joy_t         joystick_0,
	input  joy_t         joystick_1,
	input  status_t      status,
	input  logic [1:0]   board_buttons,
	output game_ctrl_t   game_ctrl,
	output logic         game_reset
);

	// Joystick bit positions
	localparam int JOY_RIGHT   = 0;
	localparam int JOY_LEFT    = 1;
	localparam int JOY_DOWN    = 2;
	localparam int JOY_UP      = 3;
	localparam int JOY_FIRE    = 4;
	localparam int JOY_BARRIER = 5;

	joy_t       joy_any;
	logic       rotate;
	game_ctrl_t ctrl_next;

	assign joy_any = joystick_0 | joystick_1; // Either player's stick
	assign rotate  = status[`STATUS_ROTATE];

	always_comb begin
		ctrl_next.coin   = key_buttons.coin;
		ctrl_next.start1 = key_buttons.start1;
		ctrl_next.start2 = key_buttons.start2;
		if (rotate) begin
			ctrl_next.left  = key_buttons.left  | joy_any[JOY_LEFT];
			ctrl_next.right = key_buttons.right | joy_any[JOY_RIGHT];
		end else begin
			// Screen turned, so vertical controls steer
			ctrl_next.left  = key_buttons.down | joy_any[JOY_DOWN];
			ctrl_next.right = key_buttons.up   | joy_any[JOY_UP];
		end
		ctrl_next.fire    = key_buttons.fire1 | joy_any[JOY_FIRE];
		ctrl_next.barrier = key_buttons.fire2 | joy_any[JOY_BARRIER];
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			game_ctrl  <= '0;
			game_reset <= 1'b0;
		end else begin
			game_ctrl  <= ctrl_next;
			game_reset <= status[`STATUS_RESET] | status[`STATUS_RESET_MENU]
				| board_buttons[1]; // Menu reset, reset entry or board button
		end
	end

endmodule

`default_nettype wire

// ==== verilog/video_shaper.sv ====
// Video shaper
// Blanks the 2-bit game colours, widens them to 6 bits, dims odd lines
// by the scanline level and drives active-low syncs, all in one stage

`default_nettype none

`include "arcade_io_defines.svh"

module video_shaper
	import arcade_io_pkg::*;
(
	input  logic        clk_sys,
	input  logic        rst_n,
	input  game_video_t game_video,
	input  status_t     status,
	input  logic        scandoubler_disable,
	output vga_out_t    vga
);

	logic       hs_q;       // Previous hs for edge detect
	logic       line_odd;   // Line parity
	logic       hs_rise;
	logic       blank;
	logic [1:0] scan_level;
	logic [1:0] dim_level;

	// ------------------------------
	// Channel shaping
	// ------------------------------
	function automatic color6_t shade(input color2_t c, input logic blank_in,
		input logic [1:0] level);
		color6_t v;
		begin
			v = blank_in ? 6'd0 : {c, c, c}; // Repeat bits to full scale
			case (level)
				2'd1: shade = v - (v >> 2); // 75%
				2'd2: shade = v >> 1;       // 50%
				2'd3: shade = v >> 2;       // 25%
				default: shade = v;
			endcase
		end
	endfunction

	always_comb begin
		blank   = (game_video.hb_bg & game_video.hb_fg) | game_video.vb;
		hs_rise = game_video.hs & ~hs_q;

		// No scanlines without the scan doubler
		if (scandoubler_disable) begin
			scan_level = 2'b00;
		end else begin
			scan_level = status[`STATUS_SCAN_LO +: 2];
		end
		dim_level = line_odd ? scan_level : 2'b00; // Even lines stay bright
	end

	// ------------------------------
	// Output register
	// ------------------------------
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			hs_q     <= 1'b0;
			line_odd <= 1'b0;
			vga.r    <= '0;
			vga.g    <= '0;
			vga.b    <= '0;
			vga.hs_n <= 1'b1;
			vga.vs_n <= 1'b1;
		end else begin
			hs_q <= game_video.hs;
			if (hs_rise) begin
				line_odd <= ~line_odd; // New line
			end
			vga.r    <= shade(game_video.r, blank, dim_level);
			vga.g    <= shade(game_video.g, blank, dim_level);
			vga.b    <= shade(game_video.b, blank, dim_level);
			vga.hs_n <= ~game_video.hs;
			vga.vs_n <= ~game_video.vs;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/sigma_delta_dac.sv ====
// First-order sigma-delta audio DAC
// The input is added to an accumulator every cycle and the carry out
// forms a 1-bit pulse-density stream

`default_nettype none

`include "arcade_io_defines.svh"

module sigma_delta_dac (
	input  logic                 clk_sys,
	input  logic                 rst_n,
	input  logic [`DAC_BITS-1:0] dac_in,
	output logic                 dac_out
);

	logic [`DAC_BITS-1:0] acc;
	logic [`DAC_BITS:0]   sum;   // One extra bit for the carry

	assign sum = {1'b0, acc} + {1'b0, dac_in};

	// ------------------------------
	// Accumulator and output bit
	// ------------------------------
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			acc     <= '0;
			dac_out <= 1'b0;
		end else begin
			acc     <= sum[`DAC_BITS-1:0];
			dac_out <= sum[`DAC_BITS]; // Carry is the pulse
		end
	end

endmodule

`default_nettype wire

// ==== verilog/arcade_io_top.sv ====
// Arcade board I/O top level
// Connects the key latch, control mapper, video shaper and audio DAC
// between the board signals and the game core

`default_nettype none

`include "arcade_io_defines.svh"

module arcade_io_top
	import arcade_io_pkg::*;
(
	input  logic        clk_sys,
	input  logic        rst_n,

	// Keyboard events
	input  logic        key_strobe,
	input  logic        key_pressed,
	input  key_code_t   key_code,

	// Menu link and board controls
	input  joy_t        joystick_0,
	input  joy_t        joystick_1,
	input  status_t     status,
	input  logic [1:0]  board_buttons,
	input  logic        scandoubler_disable,

	// From the game core
	input  game_video_t game_video,
	input  audio_t      audio,

	// To the game core
	output game_ctrl_t  game_ctrl,
	output logic        game_reset,

	// Board outputs
	output vga_out_t    vga,
	output logic        audio_l,
	output logic        audio_r
);

	key_buttons_t         key_buttons;
	logic [`DAC_BITS-1:0] dac_in;

	assign dac_in  = {audio, 3'b000}; // Scale 12-bit sample to DAC width
	assign audio_r = audio_l;         // Mono

	// ------------------------------
	// Controls
	// ------------------------------
	key_latch u_key_latch (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.key_strobe  (key_strobe),
		.key_pressed (key_pressed),
		.key_code    (key_code),
		.buttons     (key_buttons)
	);

	control_mapper u_control_mapper (
		.clk_sys       (clk_sys),
		.rst_n         (rst_n),
		.key_buttons   (key_buttons),
		.joystick_0    (joystick_0),
		.joystick_1    (joystick_1),
		.status        (status),
		.board_buttons (board_buttons),
		.game_ctrl     (game_ctrl),
		.game_reset    (game_reset)
	);

	// ------------------------------
	// Video and audio
	// ------------------------------
	video_shaper u_video_shaper (
		.clk_sys             (clk_sys),
		.rst_n               (rst_n),
		.game_video          (game_video),
		.status              (status),
		.scandoubler_disable (scandoubler_disable),
		.vga                 (vga)
	);

	sigma_delta_dac u_sigma_delta_dac (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.dac_in  (dac_in),
		.dac_out (audio_l)
	);

endmodule

`default_nettype wire

// ==== test/arcade_io_tb.sv ====
// Arcade board I/O testbench
// Applies a table of key, joystick, status and video rows one per cycle,
// checks controls, reset and VGA at fixed latency, then the DAC density

`default_nettype none

`include "arcade_io_defines.svh"

module arcade_io_tb
	import arcade_io_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ns;

	typedef struct packed {
		logic        rnd;      // Joysticks drawn at random
		logic        strobe;
		logic        pressed;
		key_code_t   code;
		joy_t        j0;
		joy_t        j1;
		status_t     status;
		logic [1:0]  bb;
		logic        sd;
		game_video_t video;
		game_ctrl_t  exp_ctrl;
		logic        exp_rst;
		vga_out_t    exp_vga;
	} row_t;

	logic        clk_sys = 1'b0;
	logic        rst_n;
	logic        key_strobe;
	logic        key_pressed;
	key_code_t   key_code;
	joy_t        joystick_0;
	joy_t        joystick_1;
	status_t     status;
	logic [1:0]  board_buttons;
	logic        scandoubler_disable;
	game_video_t game_video;
	audio_t      audio;
	game_ctrl_t  game_ctrl;
	logic        game_reset;
	vga_out_t    vga;
	logic        audio_l;
	logic        audio_r;

	row_t rows[$];
	int   row_idx;

	arcade_io_top dut (
		.clk_sys             (clk_sys),
		.rst_n               (rst_n),
		.key_strobe          (key_strobe),
		.key_pressed         (key_pressed),
		.key_code            (key_code),
		.joystick_0          (joystick_0),
		.joystick_1          (joystick_1),
		.status              (status),
		.board_buttons       (board_buttons),
		.scandoubler_disable (scandoubler_disable),
		.game_video          (game_video),
		.audio               (audio),
		.game_ctrl           (game_ctrl),
		.game_reset          (game_reset),
		.vga                 (vga),
		.audio_l             (audio_l),
		.audio_r             (audio_r)
	);

	initial begin
		forever #50 clk_sys = ~clk_sys;
	end

	// ------------------------------
	// Reference rules and checks
	// ------------------------------
	function automatic game_ctrl_t joy_to_ctrl(input joy_t j0, input joy_t j1, input logic rotate);
		joy_t       j;
		game_ctrl_t c;
		j = j0 | j1;
		c = '0;
		c.left    = rotate ? j[1] : j[2]; // Down steers left when not rotated
		c.right   = rotate ? j[0] : j[3];
		c.fire    = j[4];
		c.barrier = j[5];
		return c;
	endfunction

	task automatic report_mismatch(input string msg);
		$display("FAIL %0t: %s (row %0d)", $time, msg, row_idx);
		$display("sim failed");
		$fatal(1, "Output mismatch");
	endtask

	task automatic check_ctrl(input game_ctrl_t got, input game_ctrl_t exp);
		if (got !== exp)
			report_mismatch($sformatf("game_ctrl expected %h got %h", exp, got));
	endtask

	task automatic check_reset(input logic got, input logic exp);
		if (got !== exp)
			report_mismatch($sformatf("game_reset expected %b got %b", exp, got));
	endtask

	task automatic check_vga(input vga_out_t got, input vga_out_t exp);
		if (got !== exp)
			report_mismatch($sformatf("vga expected %h got %h", exp, got));
	endtask

	task automatic check_density(input int got, input int exp, input string what);
		if (got != exp)
			report_mismatch($sformatf("%s ones expected %0d got %0d", what, exp, got));
	endtask

	// ------------------------------
	// Table building
	// ------------------------------
	task automatic add_ctrl(input logic rnd, input logic strobe, input logic pressed,
		input key_code_t code, input joy_t j0, input joy_t j1, input status_t st,
		input logic [1:0] bb, input game_ctrl_t exp_ctrl, input logic exp_rst);
		row_t r;
		r = '0;
		r.rnd      = rnd;
		r.strobe   = strobe;
		r.pressed  = pressed;
		r.code     = code;
		r.j0       = j0;
		r.j1       = j1;
		r.status   = st;
		r.bb       = bb;
		r.exp_ctrl = exp_ctrl;
		r.exp_rst  = exp_rst;
		r.exp_vga  = 20'h00003; // Black with syncs idle high
		rows.push_back(r);
	endtask

	task automatic add_video(input status_t st, input logic sd, input game_video_t video,
		input vga_out_t exp_vga);
		row_t r;
		r = '0;
		r.status  = st;
		r.sd      = sd;
		r.video   = video;
		r.exp_vga = exp_vga;
		rows.push_back(r);
	endtask

	task automatic drive_row(input row_t r);
		key_strobe          = r.strobe;
		key_pressed         = r.pressed;
		key_code            = r.code;
		joystick_0          = r.j0;
		joystick_1          = r.j1;
		status              = r.status;
		board_buttons       = r.bb;
		scandoubler_disable = r.sd;
		game_video          = r.video;
	endtask

	task automatic check_dac(input audio_t value);
		int ones_l;
		int ones_r;
		int n;
		ones_l = 0;
		ones_r = 0;
		audio  = value;
		for (n = 0; n < 32768; n++) begin
			@(negedge clk_sys);
			if (audio_l)
				ones_l++;
			if (audio_r)
				ones_r++;
		end
		check_density(ones_l, 8 * int'(value), "audio_l");
		check_density(ones_r, 8 * int'(value), "audio_r");
	endtask

	task automatic build_table();
		// Up and down steer with rotate off and unknown 1Ch is ignored
		add_ctrl(1'b0, 1'b0, 1'b0, 8'h00, 8'h00, 8'h00, 32'h00, 2'd0, 7'h00, 1'b0);
		add_ctrl(1'b0, 1'b1, 1'b1, 8'h75, 8'h00, 8'h00, 32'h00, 2'd0, 7'h00, 1'b0);
		add_ctrl(1'b0, 1'b1, 1'b1, 8'h72, 8'h00, 8'h00, 32'h00, 2'd0, 7'h04, 1'b0);
		add_ctrl(1'b0, 1'b1, 1'b0, 8'h75, 8'h00, 8'h00, 32'h00, 2'd0, 7'h0C, 1'b0);
		add_ctrl(1'b0, 1'b1, 1'b0, 8'h72, 8'h00, 8'h00, 32'h00, 2'd0, 7'h08, 1'b0);
		add_ctrl(1'b0, 1'b1, 1'b1, 8'h6B, 8'h00, 8'h00, 32'h04, 2'd0, 7'h00, 1'b0);
		add_ctrl(1'b0, 1'b1, 1'b1, 8'h74, 8'h00, 8'h00, 32'h04, 2'd0, 7'h08, 1'b0);
		add_ctrl(1'b0, 1'b1, 1'b1, 8'h1C, 8'h00, 8'h00, 32'h04, 2'd0, 7'h0C, 1'b0);
		add_ctrl(1'b0, 1'b1, 1'b0, 8'h6B, 8'h00, 8'h00, 32'h04, 2'd0, 7'h0C, 1'b0);
		add_ctrl(1'b0, 1'b1, 1'b0, 8'h74, 8'h00, 8'h00, 32'h04, 2'd0, 7'h04, 1'b0);
		add_ctrl(1'b0, 1'b1, 1'b1, 8'h76, 8'h00, 8'h00, 32'h04, 2'd0, 7'h00, 1'b0);
		add_ctrl(1'b0, 1'b1, 1'b1, 8'h05, 8'h00, 8'h00, 32'h04, 2'd0, 7'h40, 1'b0);
		add_ctrl(1'b0, 1'b1, 1'b1, 8'h06, 8'h00, 8'h00, 32'h04, 2'd0, 7'h60, 1'b0);
		add_ctrl(1'b0, 1'b1, 1'b1, 8'h29, 8'h00, 8'h00, 32'h04, 2'd0, 7'h70, 1'b0);
		add_ctrl(1'b0, 1'b1, 1'b1, 8'h11, 8'h00, 8'h00, 32'h04, 2'd0, 7'h72, 1'b0);
		add_ctrl(1'b0, 1'b1, 1'b0, 8'h1C, 8'h00, 8'h00, 32'h04, 2'd0, 7'h73, 1'b0);
		add_ctrl(1'b0, 1'b1, 1'b0, 8'h76, 8'h00, 8'h00, 32'h04, 2'd0, 7'h73, 1'b0);
		add_ctrl(1'b0, 1'b1, 1'b0, 8'h05, 8'h00, 8'h00, 32'h04, 2'd0, 7'h33, 1'b0);
		add_ctrl(1'b0, 1'b1, 1'b0, 8'h06, 8'h00, 8'h00, 32'h04, 2'd0, 7'h13, 1'b0);
		add_ctrl(1'b0, 1'b1, 1'b0, 8'h29, 8'h00, 8'h00, 32'h04, 2'd0, 7'h03, 1'b0);
		add_ctrl(1'b0, 1'b1, 1'b0, 8'h11, 8'h00, 8'h00, 32'h04, 2'd0, 7'h01, 1'b0);
		add_ctrl(1'b0, 1'b0, 1'b0, 8'h00, 8'h00, 8'h00, 32'h04, 2'd0, 7'h00, 1'b0);
		// Expected holds only the key part for random sticks
		add_ctrl(1'b1, 1'b1, 1'b1, 8'h29, 8'h00, 8'h00, 32'h00, 2'd0, 7'h00, 1'b0);
		add_ctrl(1'b1, 1'b0, 1'b0, 8'h00, 8'h00, 8'h00, 32'h00, 2'd0, 7'h02, 1'b0);
		add_ctrl(1'b1, 1'b0, 1'b0, 8'h00, 8'h00, 8'h00, 32'h04, 2'd0, 7'h02, 1'b0);
		add_ctrl(1'b1, 1'b1, 1'b1, 8'h11, 8'h00, 8'h00, 32'h04, 2'd0, 7'h02, 1'b0);
		add_ctrl(1'b1, 1'b0, 1'b0, 8'h00, 8'h00, 8'h00, 32'h00, 2'd0, 7'h03, 1'b0);
		add_ctrl(1'b1, 1'b0, 1'b0, 8'h00, 8'h00, 8'h00, 32'h04, 2'd0, 7'h03, 1'b0);
		add_ctrl(1'b1, 1'b1, 1'b0, 8'h29, 8'h00, 8'h00, 32'h00, 2'd0, 7'h03, 1'b0);
		add_ctrl(1'b1, 1'b1, 1'b0, 8'h11, 8'h00, 8'h00, 32'h04, 2'd0, 7'h01, 1'b0);
		add_ctrl(1'b1, 1'b0, 1'b0, 8'h00, 8'h00, 8'h00, 32'h00, 2'd0, 7'h00, 1'b0);
		add_ctrl(1'b1, 1'b0, 1'b0, 8'h00, 8'h00, 8'h00, 32'h04, 2'd0, 7'h00, 1'b0);
		add_ctrl(1'b0, 1'b0, 1'b0, 8'h00, 8'h02, 8'h04, 32'h00, 2'd0, 7'h08, 1'b0);
		add_ctrl(1'b0, 1'b0, 1'b0, 8'h00, 8'h01, 8'h08, 32'h04, 2'd0, 7'h04, 1'b0);
		// Game reset sources
		add_ctrl(1'b0, 1'b0, 1'b0, 8'h00, 8'h00, 8'h00, 32'h01, 2'd0, 7'h00, 1'b1);
		add_ctrl(1'b0, 1'b0, 1'b0, 8'h00, 8'h00, 8'h00, 32'h40, 2'd0, 7'h00, 1'b1);
		add_ctrl(1'b0, 1'b0, 1'b0, 8'h00, 8'h00, 8'h00, 32'h00, 2'd2, 7'h00, 1'b1);
		add_ctrl(1'b0, 1'b0, 1'b0, 8'h00, 8'h00, 8'h00, 32'h00, 2'd1, 7'h00, 1'b0);
		// Blanking, widening and syncs on an even line
		add_video(32'h18, 1'b0, 11'h720, 20'hFEA57);
		add_video(32'h18, 1'b0, 11'h724, 20'hFEA57);
		add_video(32'h18, 1'b0, 11'h722, 20'hFEA57);
		add_video(32'h18, 1'b0, 11'h726, 20'h00003);
		add_video(32'h18, 1'b0, 11'h721, 20'h00003);
		add_video(32'h18, 1'b0, 11'h728, 20'hFEA56);
		add_video(32'h18, 1'b0, 11'h730, 20'hFEA55); // First hs edge and odd lines from here
		// Scanline levels on the odd line
		add_video(32'h00, 1'b0, 11'h730, 20'hFEA55);
		add_video(32'h08, 1'b0, 11'h720, 20'hC2043);
		add_video(32'h10, 1'b0, 11'h720, 20'h7D52B);
		add_video(32'h18, 1'b0, 11'h720, 20'h3CA17);
		add_video(32'h18, 1'b1, 11'h720, 20'hFEA57);
		add_video(32'h18, 1'b0, 11'h730, 20'h3CA15);
		add_video(32'h18, 1'b0, 11'h720, 20'hFEA57);
		add_video(32'h18, 1'b0, 11'h730, 20'hFEA55);
		add_video(32'h18, 1'b0, 11'h720, 20'h3CA17);
		add_video(32'h18, 1'b0, 11'h721, 20'h00003);
	endtask

	// ------------------------------
	// Main sequence
	// ------------------------------
	initial begin
		int   i;
		row_t r;
		void'($urandom(94721));
		row_idx   = -1;
		rst_n     = 1'b0;
		drive_row('0);
		audio = '0;
		build_table();

		repeat (2) @(negedge clk_sys);
		rst_n = 1'b1;
		@(negedge clk_sys);
		check_ctrl(game_ctrl, 7'h00); // Reset values
		check_reset(game_reset, 1'b0);
		check_vga(vga, 20'h00003);

		for (i = 0; i < rows.size(); i++) begin
			row_idx = i;
			r = rows[i];
			if (r.rnd) begin
				r.j0 = joy_t'($urandom());
				r.j1 = joy_t'($urandom());
				r.exp_ctrl = r.exp_ctrl | joy_to_ctrl(r.j0, r.j1, r.status[`STATUS_ROTATE]);
			end
			drive_row(r);
			@(negedge clk_sys);
			check_ctrl(game_ctrl, r.exp_ctrl);
			check_reset(game_reset, r.exp_rst);
			check_vga(vga, r.exp_vga);
		end

		row_idx = rows.size();
		drive_row('0);
		check_dac(12'h5A3);
		check_dac(audio_t'($urandom()));

		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+include
verilog/arcade_io_pkg.sv
verilog/key_latch.sv
verilog/control_mapper.sv
verilog/video_shaper.sv
verilog/sigma_delta_dac.sv
verilog/arcade_io_top.sv
test/arcade_io_tb.sv

// ==== Makefile ====
# Verilator simulation of the arcade board I/O testbench

TOP := arcade_io_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build output"

test:
	verilator --binary --timing --timescale 1ns/1ps -f verilog.f \
		--top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir
